// File: common/isp_pkg.sv
// Shared widths, pixel, position and 4:2:2 pair structs, BT.601 conversion constants
`default_nettype none

package isp_pkg;

    // Component and coordinate widths
    // The shift-add coefficients assume 8-bit precision
    parameter int COMP_W  = 8;
    parameter int COORD_W = 12;

    // BT.601 luma weights, sum is 256
    parameter int Y_COEF_R = 77;    // 0.299 * 256
    parameter int Y_COEF_G = 150;   // 0.587 * 256
    parameter int Y_COEF_B = 29;    // 0.114 * 256

    // Chroma scale factors
    parameter int KCB = 144;        // 1 / 1.772 * 256
    parameter int KCR = 182;        // 1 / 1.402 * 256

    parameter int CHROMA_OFFSET = 128;  // Mid-scale for Cb and Cr

    // One RGB input pixel
    typedef struct packed {
        logic [COMP_W-1:0] r;
        logic [COMP_W-1:0] g;
        logic [COMP_W-1:0] b;
    } rgb_pix_t;

    // One converted pixel at full chroma resolution
    typedef struct packed {
        logic [COMP_W-1:0] y;
        logic [COMP_W-1:0] cb;
        logic [COMP_W-1:0] cr;
    } ycbcr_pix_t;

    // Raster position of a pixel
    typedef struct packed {
        logic [COORD_W-1:0] col;
        logic [COORD_W-1:0] line;
        logic               sof;    // First pixel of a frame
    } raster_pos_t;

    // Output word, two horizontally adjacent pixels with shared chroma
    typedef struct packed {
        logic [COMP_W-1:0]  y0;         // Even pixel luma
        logic [COMP_W-1:0]  y1;         // Odd pixel luma
        logic [COMP_W-1:0]  cb;         // Mean of both Cb
        logic [COMP_W-1:0]  cr;         // Mean of both Cr
        logic [COORD_W-1:0] pair_col;   // Column / 2
        logic [COORD_W-1:0] line;
        logic               sof;
    } ycbcr422_pair_t;

endpackage

`default_nettype wire

// File: rgb2yuv/rgb2yuv.sv
// RGB to YCbCr BT.601 converter, input capture plus three shift-add stages, stalled by hold
`timescale 1ns/100ps
`default_nettype none

module rgb2yuv (
    input  logic                clk,
    input  logic                resetn,
    input  isp_pkg::rgb_pix_t   rgb,
    input  logic                rgb_valid,
    input  logic                frame_valid,
    input  logic                line_valid,
    input  logic                hold,
    output isp_pkg::ycbcr_pix_t pix_ycc,
    output logic                pix_valid,
    output logic                frame_valid_out,
    output logic                line_valid_out
);

    localparam int PROD_W = isp_pkg::COMP_W + 8;   // Component times 8-bit weight
    localparam int SUM_W  = PROD_W + 1;            // Sum of three weighted terms
    localparam int DIFF_W = isp_pkg::COMP_W + 1;   // Signed B-Y and R-Y
    localparam int CH_W   = DIFF_W + 9;            // Scaled difference plus offset

    // Input capture
    isp_pkg::rgb_pix_t in_pix;
    logic              in_valid;
    logic              in_fv;
    logic              in_lv;

    always_ff @(posedge clk) begin
        if (rgb_valid && !hold) begin
            in_pix <= rgb;
        end
    end

    // Stage 0, weighted products
    logic [PROD_W-1:0] prod_r_c, prod_g_c, prod_b_c;
    logic [PROD_W-1:0] prod_r, prod_g, prod_b;
    logic [isp_pkg::COMP_W-1:0] s0_r, s0_b;    // Kept for the differences
    logic s0_valid;
    logic s0_fv;
    logic s0_lv;

    always_comb begin
        // Y_COEF_R = 77 = 0100_1101
        prod_r_c = (PROD_W'(in_pix.r) << 6) + (PROD_W'(in_pix.r) << 3)
                 + (PROD_W'(in_pix.r) << 2) +  PROD_W'(in_pix.r);
        // Y_COEF_G = 150 = 1001_0110
        prod_g_c = (PROD_W'(in_pix.g) << 7) + (PROD_W'(in_pix.g) << 4)
                 + (PROD_W'(in_pix.g) << 2) + (PROD_W'(in_pix.g) << 1);
        // Y_COEF_B = 29 = 0001_1101
        prod_b_c = (PROD_W'(in_pix.b) << 4) + (PROD_W'(in_pix.b) << 3)
                 + (PROD_W'(in_pix.b) << 2) +  PROD_W'(in_pix.b);
    end

    always_ff @(posedge clk) begin
        if (in_valid && !hold) begin
            prod_r <= prod_r_c;
            prod_g <= prod_g_c;
            prod_b <= prod_b_c;
            s0_r   <= in_pix.r;
            s0_b   <= in_pix.b;
        end
    end

    // Stage 1, luma and colour differences
    logic [SUM_W-1:0]           sum_c;
    logic [isp_pkg::COMP_W-1:0] y_c;
    logic signed [DIFF_W-1:0]   u_c, v_c;
    logic [isp_pkg::COMP_W-1:0] s1_y;
    logic signed [DIFF_W-1:0]   s1_u, s1_v;
    logic s1_valid;
    logic s1_fv;
    logic s1_lv;

    always_comb begin
        // Weights sum to 256 so Y stays within 0..255 after rounding
        sum_c = SUM_W'(prod_r) + SUM_W'(prod_g) + SUM_W'(prod_b) + SUM_W'(1 << 7);
        y_c   = sum_c[8 +: isp_pkg::COMP_W];
        u_c   = $signed({1'b0, s0_b}) - $signed({1'b0, y_c});  // B-Y, about +/-226
        v_c   = $signed({1'b0, s0_r}) - $signed({1'b0, y_c});  // R-Y, about +/-179
    end

    always_ff @(posedge clk) begin
        if (s0_valid && !hold) begin
            s1_y <= y_c;
            s1_u <= u_c;
            s1_v <= v_c;
        end
    end

    // Stage 2, chroma scaling with offset and rounding
    logic signed [CH_W-1:0] cb_c, cr_c;

    always_comb begin
        // KCB = 144 = 1001_0000
        cb_c = (CH_W'(isp_pkg::CHROMA_OFFSET) << 8) + CH_W'(1 << 7)
             + (CH_W'(s1_u) << 7) + (CH_W'(s1_u) << 4);
        // KCR = 182 = 1011_0110
        cr_c = (CH_W'(isp_pkg::CHROMA_OFFSET) << 8) + CH_W'(1 << 7)
             + (CH_W'(s1_v) << 7) + (CH_W'(s1_v) << 5) + (CH_W'(s1_v) << 4)
             + (CH_W'(s1_v) << 2) + (CH_W'(s1_v) << 1);
    end

    always_ff @(posedge clk) begin
        if (s1_valid && !hold) begin
            pix_ycc.y  <= s1_y;
            pix_ycc.cb <= cb_c[8 +: isp_pkg::COMP_W];  // Truncated to 8 bits
            pix_ycc.cr <= cr_c[8 +: isp_pkg::COMP_W];
        end
    end

    // Valid and level pipeline, same depth as the data
    always_ff @(posedge clk) begin
        if (!resetn) begin
            in_valid        <= 1'b0;
            in_fv           <= 1'b0;
            in_lv           <= 1'b0;
            s0_valid        <= 1'b0;
            s0_fv           <= 1'b0;
            s0_lv           <= 1'b0;
            s1_valid        <= 1'b0;
            s1_fv           <= 1'b0;
            s1_lv           <= 1'b0;
            pix_valid       <= 1'b0;
            frame_valid_out <= 1'b0;
            line_valid_out  <= 1'b0;
        end else if (!hold) begin
            in_valid        <= rgb_valid;
            in_fv           <= frame_valid;
            in_lv           <= line_valid;
            s0_valid        <= in_valid;
            s0_fv           <= in_fv;
            s0_lv           <= in_lv;
            s1_valid        <= s0_valid;
            s1_fv           <= s0_fv;
            s1_lv           <= s0_lv;
            pix_valid       <= s1_valid;
            frame_valid_out <= s1_fv;
            line_valid_out  <= s1_lv;
        end
    end

endmodule

`default_nettype wire

// File: logic/raster_tracker.sv
// Column and line counters with start-of-frame flag, delayed to line up with the converter
`timescale 1ns/100ps
`default_nettype none

module raster_tracker (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 rgb_valid,
    input  logic                 frame_valid,
    input  logic                 line_valid,
    input  logic                 hold,
    output isp_pkg::raster_pos_t pos
);

    logic [isp_pkg::COORD_W-1:0] col_cnt;   // Column of the next pixel
    logic [isp_pkg::COORD_W-1:0] line_cnt;  // Current line in the frame
    logic                        sof_pending;
    logic                        lv_q;      // For the line end edge
    logic                        take;

    isp_pkg::raster_pos_t pos_cap;          // Same edge as the converter input capture
    isp_pkg::raster_pos_t pos_pipe [3];     // Matches converter stages 0..2

    assign take = rgb_valid && line_valid && !hold;

    // Counters
    always_ff @(posedge clk) begin
        if (!resetn) begin
            col_cnt     <= '0;
            line_cnt    <= '0;
            sof_pending <= 1'b0;
            lv_q        <= 1'b0;
        end else if (!hold) begin
            lv_q <= line_valid;
            if (!line_valid)
                col_cnt <= '0;                      // Restart between lines
            else if (rgb_valid)
                col_cnt <= col_cnt + 1'b1;
            if (!frame_valid)
                line_cnt <= '0;                     // Restart between frames
            else if (lv_q && !line_valid)
                line_cnt <= line_cnt + 1'b1;        // Line end
            if (!frame_valid)
                sof_pending <= 1'b1;                // Armed during frame gap
            else if (rgb_valid && line_valid)
                sof_pending <= 1'b0;                // Consumed by first pixel
        end
    end

    // Position of each accepted pixel
    always_ff @(posedge clk) begin
        if (take) begin
            pos_cap.col  <= col_cnt;
            pos_cap.line <= line_cnt;
            pos_cap.sof  <= sof_pending;
        end
    end

    // Delay chain, advances whenever the converter does
    always_ff @(posedge clk) begin
        if (!hold) begin
            pos_pipe[0] <= pos_cap;
            pos_pipe[1] <= pos_pipe[0];
            pos_pipe[2] <= pos_pipe[1];
        end
    end

    assign pos = pos_pipe[2];

endmodule

`default_nettype wire

// File: logic/chroma_subsampler.sv
// 4:2:2 chroma subsampler, pairs even and odd pixels and averages Cb and Cr with rounding
`timescale 1ns/100ps
`default_nettype none

module chroma_subsampler (
    input  logic                    clk,
    input  logic                    resetn,
    input  isp_pkg::ycbcr_pix_t     pix_ycc,
    input  logic                    pix_valid,
    input  isp_pkg::raster_pos_t    pos,
    input  logic                    hold,
    output isp_pkg::ycbcr422_pair_t pair,
    output logic                    pair_valid
);

    localparam int AVG_W = isp_pkg::COMP_W + 1;    // Sum of two components

    // Stored even pixel
    isp_pkg::ycbcr_pix_t         even_pix;
    logic [isp_pkg::COORD_W-1:0] even_pair_col;
    logic [isp_pkg::COORD_W-1:0] even_line;
    logic                        even_sof;
    logic                        have_even;

    logic                       take;
    logic                       is_odd;
    logic                       emit;
    logic [AVG_W-1:0]           cb_sum, cr_sum;
    logic [isp_pkg::COMP_W-1:0] cb_avg, cr_avg;

    assign take   = pix_valid && !hold;
    assign is_odd = pos.col[0];
    assign emit   = take && is_odd && have_even;   // Odd pixel completes a pair

    // Rounded mean, (a + b + 1) >> 1
    always_comb begin
        cb_sum = AVG_W'(even_pix.cb) + AVG_W'(pix_ycc.cb) + AVG_W'(1);
        cr_sum = AVG_W'(even_pix.cr) + AVG_W'(pix_ycc.cr) + AVG_W'(1);
        cb_avg = cb_sum[AVG_W-1:1];
        cr_avg = cr_sum[AVG_W-1:1];
    end

    // Even pixel store
    always_ff @(posedge clk) begin
        if (take && !is_odd) begin
            even_pix      <= pix_ycc;
            even_pair_col <= {1'b0, pos.col[isp_pkg::COORD_W-1:1]};
            even_line     <= pos.line;
            even_sof      <= pos.sof;
        end
    end

    // Output pair, position taken from the even pixel
    always_ff @(posedge clk) begin
        if (emit) begin
            pair.y0       <= even_pix.y;
            pair.y1       <= pix_ycc.y;
            pair.cb       <= cb_avg;
            pair.cr       <= cr_avg;
            pair.pair_col <= even_pair_col;
            pair.line     <= even_line;
            pair.sof      <= even_sof;
        end
    end

    // Control
    always_ff @(posedge clk) begin
        if (!resetn) begin
            have_even  <= 1'b0;
            pair_valid <= 1'b0;
        end else if (!hold) begin
            pair_valid <= emit;
            if (take) begin
                // Even sets, odd clears; a lone odd pixel is dropped
                have_even <= !is_odd;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/color_pipe_top.sv
// Colour pipe top level, converter, raster tracker and 4:2:2 subsampler sharing one hold
`timescale 1ns/100ps
`default_nettype none

module color_pipe_top (
    input  logic                    clk,
    input  logic                    resetn,
    input  isp_pkg::rgb_pix_t       rgb,
    input  logic                    rgb_valid,
    input  logic                    frame_valid,
    input  logic                    line_valid,
    output logic                    rgb_hold,
    output isp_pkg::ycbcr422_pair_t pair,
    output logic                    pair_valid,
    input  logic                    pair_hold
);

    isp_pkg::ycbcr_pix_t  pix_ycc;
    logic                 pix_valid;
    isp_pkg::raster_pos_t pos;

    // Downstream stall goes straight back upstream
    assign rgb_hold = pair_hold;

    rgb2yuv rgb2yuv_inst (
        .clk             (clk),
        .resetn          (resetn),
        .rgb             (rgb),
        .rgb_valid       (rgb_valid),
        .frame_valid     (frame_valid),
        .line_valid      (line_valid),
        .hold            (pair_hold),
        .pix_ycc         (pix_ycc),
        .pix_valid       (pix_valid),
        .frame_valid_out (),            // Position comes from the tracker
        .line_valid_out  ()
    );

    raster_tracker raster_tracker_inst (
        .clk         (clk),
        .resetn      (resetn),
        .rgb_valid   (rgb_valid),
        .frame_valid (frame_valid),
        .line_valid  (line_valid),
        .hold        (pair_hold),
        .pos         (pos)              // Aligned with pix_valid
    );

    chroma_subsampler chroma_subsampler_inst (
        .clk        (clk),
        .resetn     (resetn),
        .pix_ycc    (pix_ycc),
        .pix_valid  (pix_valid),
        .pos        (pos),
        .hold       (pair_hold),
        .pair       (pair),
        .pair_valid (pair_valid)
    );

endmodule

`default_nettype wire

// File: testbench/color_pipe_assertions.sv
// Bound checker with concurrent assertions on reset, hold pass-through and output stability
`timescale 1ns/100ps
`default_nettype none

module color_pipe_assertions (
    input logic                    clk,
    input logic                    resetn,
    input isp_pkg::ycbcr422_pair_t pair,
    input logic                    pair_valid,
    input logic                    pair_hold,
    input logic                    rgb_hold
);

    int unsigned fail_count = 0;    // Assertion failures so far

    // Reset clears the output strobe
    reset_clears_valid: assert property (@(posedge clk) !resetn |=> !pair_valid)
        else begin fail_count++; $error("pair_valid high after a reset cycle"); end

    // A held output word does not move
    hold_freezes_pair: assert property (@(posedge clk) disable iff (!resetn)
        pair_hold |=> $stable(pair_valid) && (!pair_valid || $stable(pair)))
        else begin fail_count++; $error("pair or pair_valid changed under pair_hold"); end

    hold_passes_back: assert property (@(posedge clk) rgb_hold == pair_hold)
        else begin fail_count++; $error("rgb_hold differs from pair_hold"); end

endmodule

bind color_pipe_top color_pipe_assertions color_pipe_assertions_inst (
    .clk        (clk),
    .resetn     (resetn),
    .pair       (pair),
    .pair_valid (pair_valid),
    .pair_hold  (pair_hold),
    .rgb_hold   (rgb_hold)
);

`default_nettype wire

// File: testbench/color_pipe_tb.sv
// Colour pipe testbench, LFSR raster stimulus, reference pair queue, latency check, timeout
`timescale 1ns/100ps
`default_nettype none

module color_pipe_tb;

    localparam int COMP_W    = isp_pkg::COMP_W;
    localparam int COORD_W   = isp_pkg::COORD_W;
    localparam int N_FRAMES  = 8;       // Random frames, second half under back-pressure
    localparam int MAX_LINES = 4;
    localparam int MAX_LEN   = 32;
    // Worst case cycles per frame, idle pixels and gaps included
    localparam int FRAME_CYC = MAX_LINES * (2 * MAX_LEN + 5) + 5;
    localparam int LIMIT     = 4 * (N_FRAMES + 1) * FRAME_CYC + 200;  // Room for hold cycles

    logic                    clk;
    logic                    resetn;
    isp_pkg::rgb_pix_t       rgb;
    logic                    rgb_valid;
    logic                    frame_valid;
    logic                    line_valid;
    logic                    rgb_hold;
    isp_pkg::ycbcr422_pair_t pair;
    logic                    pair_valid;
    logic                    pair_hold;

    logic [31:0] lfsr = 32'h442d_db05;
    string       test_name = "reset";
    int          errors = 0;
    int          compared = 0;
    int          cycles = 0;
    int          adv = 0;               // Edges with hold low
    logic        hold_q = 1'b1;         // pair_hold at the last edge
    logic        hold_on = 1'b0;        // Random back-pressure enable
    logic        known_mode = 1'b0;
    int          known_idx = 0;
    int          cur_col;
    int          cur_line;
    logic        even_sof;
    isp_pkg::rgb_pix_t       known_pix [16];
    isp_pkg::ycbcr_pix_t     even_exp;  // Model copy of the stored even pixel
    isp_pkg::ycbcr422_pair_t exp_q [$];
    int                      tag_q [$]; // adv count at acceptance of the odd pixel

    color_pipe_top color_pipe_top_inst (
        .clk         (clk),
        .resetn      (resetn),
        .rgb         (rgb),
        .rgb_valid   (rgb_valid),
        .frame_valid (frame_valid),
        .line_valid  (line_valid),
        .rgb_hold    (rgb_hold),
        .pair        (pair),
        .pair_valid  (pair_valid),
        .pair_hold   (pair_hold)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Cycle count, hold history and timeout
    always @(posedge clk) begin
        cycles <= cycles + 1;
        hold_q <= pair_hold;
        if (!pair_hold)
            adv <= adv + 1;
        if (cycles >= LIMIT) begin
            $display("simulation timed out after %0d cycles", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return r;
    endfunction

    function automatic isp_pkg::rgb_pix_t random_pix();
        logic [23:0] w;
        w = 24'(rand_bits(24));
        return w;
    endfunction

    function automatic isp_pkg::rgb_pix_t next_pix();
        if (known_mode) begin
            known_idx++;
            return known_pix[known_idx - 1];
        end
        return random_pix();
    endfunction

    // Reference BT.601 conversion from the package constants
    function automatic isp_pkg::ycbcr_pix_t convert(input isp_pkg::rgb_pix_t p);
        isp_pkg::ycbcr_pix_t c;
        int y;
        int cb;
        int cr;
        y  = (isp_pkg::Y_COEF_R * int'(p.r) + isp_pkg::Y_COEF_G * int'(p.g)
            + isp_pkg::Y_COEF_B * int'(p.b) + 128) >>> 8;
        cb = (isp_pkg::CHROMA_OFFSET * 256 + isp_pkg::KCB * (int'(p.b) - y) + 128) >>> 8;
        cr = (isp_pkg::CHROMA_OFFSET * 256 + isp_pkg::KCR * (int'(p.r) - y) + 128) >>> 8;
        c.y  = y[COMP_W-1:0];
        c.cb = cb[COMP_W-1:0];          // Wraps like the 8-bit output
        c.cr = cr[COMP_W-1:0];
        return c;
    endfunction

    // Even pixel is kept, odd pixel completes the expected pair
    task automatic model_pixel(input isp_pkg::rgb_pix_t p);
        isp_pkg::ycbcr_pix_t     c;
        isp_pkg::ycbcr422_pair_t e;
        c = convert(p);
        if (cur_col % 2 == 0) begin
            even_exp = c;
            even_sof = (cur_line == 0) && (cur_col == 0);
        end else begin
            e.y0       = even_exp.y;
            e.y1       = c.y;
            e.cb       = COMP_W'((int'(even_exp.cb) + int'(c.cb) + 1) >> 1);
            e.cr       = COMP_W'((int'(even_exp.cr) + int'(c.cr) + 1) >> 1);
            e.pair_col = COORD_W'(cur_col / 2);
            e.line     = COORD_W'(cur_line);
            e.sof      = even_sof;
            exp_q.push_back(e);
            tag_q.push_back(adv);
        end
    endtask

    // One input cycle, repeated while held; called and returns on a falling edge
    task automatic drive_cycle(input isp_pkg::rgb_pix_t p, input logic v,
                               input logic fv, input logic lv);
        logic taken;
        taken       = 1'b0;
        rgb         = p;
        rgb_valid   = v;
        frame_valid = fv;
        line_valid  = lv;
        while (!taken) begin
            pair_hold = hold_on && (rand_bits(1) != 0);
            @(posedge clk);
            taken = !rgb_hold;
            @(negedge clk);
        end
        if (v && lv)
            model_pixel(p);
    endtask

    // Frame gap, then lines with lead gaps and idle pixels inside
    task automatic send_frame(input int n_lines, input int line_len);
        int col;
        int ln;
        int gap;
        gap = 1 + rand_bits(2);
        repeat (gap) drive_cycle(random_pix(), 1'b0, 1'b0, 1'b0);
        for (ln = 0; ln < n_lines; ln++) begin
            gap = 1 + rand_bits(2);
            repeat (gap) drive_cycle(random_pix(), 1'b0, 1'b1, 1'b0);
            col = 0;
            while (col < line_len) begin
                if (rand_bits(3) == 0) begin
                    drive_cycle(random_pix(), 1'b0, 1'b1, 1'b1);   // Idle inside the line
                end else begin
                    cur_col  = col;
                    cur_line = ln;
                    drive_cycle(next_pix(), 1'b1, 1'b1, 1'b1);
                    col++;
                end
            end
        end
        drive_cycle(random_pix(), 1'b0, 1'b1, 1'b0);    // Last line end seen in frame
    endtask

    // Output check on the falling edge, new words only
    always @(negedge clk) begin : check_pairs
        isp_pkg::ycbcr422_pair_t e;
        int                      tag;
        if (resetn && pair_valid && !hold_q) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("[%s] pair_valid high with no pair expected, pair %h", test_name, pair);
            end else begin
                e   = exp_q.pop_front();
                tag = tag_q.pop_front();
                compared++;
                assert (pair === e) else begin
                    errors++;
                    $display("** Error [%s] pair: expected %h, actual %h", test_name, e, pair);
                end
                assert (adv - tag == 4) else begin
                    errors++;
                    $display("** Error [%s] latency: expected 4, actual %0d", test_name,
                             adv - tag);
                end
            end
        end
    end

    initial begin : stimulus
        int i;
        int n_lines;
        int len;
        int fails;
        resetn      = 1'b0;
        rgb         = '0;
        rgb_valid   = 1'b0;
        frame_valid = 1'b0;
        line_valid  = 1'b0;
        pair_hold   = 1'b0;
        // Black, white, red, green, blue, then three grays, each as a pair
        known_pix = '{24'h000000, 24'h000000, 24'hffffff, 24'hffffff,
                      24'hff0000, 24'hff0000, 24'h00ff00, 24'h00ff00,
                      24'h0000ff, 24'h0000ff, 24'h404040, 24'h404040,
                      24'hc8c8c8, 24'hc8c8c8, 24'h808080, 24'h808080};
        repeat (3) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        test_name = "idle";
        repeat (8) drive_cycle(random_pix(), 1'b0, 1'b0, 1'b0);

        test_name  = "known_colors";
        known_mode = 1'b1;
        send_frame(1, 16);
        known_mode = 1'b0;

        for (i = 0; i < N_FRAMES; i++) begin
            if (i == N_FRAMES / 2) begin
                hold_on = 1'b1;         // Random pair_hold from here on
            end
            test_name = hold_on ? "back_pressure" : "random_frames";
            n_lines   = 1 + rand_bits(2);
            len       = 8 + 2 * (rand_bits(4) % 13);    // 8..32, even
            send_frame(n_lines, len);
        end

        test_name = "drain";
        while (exp_q.size() != 0)
            drive_cycle(random_pix(), 1'b0, 1'b0, 1'b0);
        repeat (8) drive_cycle(random_pix(), 1'b0, 1'b0, 1'b0);

        fails = color_pipe_top_inst.color_pipe_assertions_inst.fail_count;
        $display("Done: %0d pairs compared, %0d check errors, %0d assertion failures",
                 compared, errors, fails);
        if (errors == 0 && fails == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
common/isp_pkg.sv
rgb2yuv/rgb2yuv.sv
logic/raster_tracker.sv
logic/chroma_subsampler.sv
logic/color_pipe_top.sv
testbench/color_pipe_assertions.sv
testbench/color_pipe_tb.sv

// File: Bender.yml
package:
  name: color_pipe

sources:
  # Package first, then RTL bottom-up
  - common/isp_pkg.sv
  - rgb2yuv/rgb2yuv.sv
  - logic/raster_tracker.sv
  - logic/chroma_subsampler.sv
  - logic/color_pipe_top.sv
  # Testbench and bound checker
  - target: simulation
    files:
      - testbench/color_pipe_assertions.sv
      - testbench/color_pipe_tb.sv
